// ==== logic/rename_pkg.sv ====
// Sizes and index types shared by the rename stage
// Pointer and count widths carry one extra bit so that full and empty differ
`default_nettype none

package rename_pkg;

  parameter int rename_width = 2;
  parameter int commit_width = 2;
  parameter int arf_size     = 32;
  parameter int prf_size     = 64;
  parameter int cp_size      = 4;

  typedef logic [$clog2(arf_size)-1:0] arf_index_t;
  typedef logic [$clog2(prf_size)-1:0] prf_index_t;
  typedef logic [$clog2(cp_size)-1:0]  cp_index_t;

  // Occupancy of the free list, also used for its wrapping pointers
  typedef logic [$clog2(prf_size):0]   free_count_t;
  typedef logic [$clog2(cp_size):0]    cp_count_t;

endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
// FIFO of free physical registers
// Allocation shows the next two entries; the caller never takes more than are free
// Restore reloads only the head, the tail keeps every release
`timescale 1ns/100ps
`default_nettype none

module free_list (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic [1:0]                                            alloc_count,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] alloc_prd,
  input  logic [rename_pkg::commit_width-1:0]                   release_valid,
  input  rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] release_prd,
  input  logic                                                  restore,
  input  rename_pkg::free_count_t                               restore_head,
  output rename_pkg::free_count_t                               head,
  output rename_pkg::free_count_t                               free_count
);

  rename_pkg::prf_index_t  fifo [rename_pkg::prf_size];
  rename_pkg::free_count_t tail;
  rename_pkg::free_count_t tail_next;
  rename_pkg::free_count_t wr_ptr [rename_pkg::commit_width];

  always_comb begin
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      alloc_prd[i] = fifo[rename_pkg::prf_index_t'(head + rename_pkg::free_count_t'(i))];
    end
  end

  // Releases pack at the tail in slot order
  always_comb begin
    tail_next = tail;
    for (int i = 0; i < rename_pkg::commit_width; i++) begin
      wr_ptr[i] = tail_next;
      tail_next = tail_next + rename_pkg::free_count_t'(release_valid[i]);
    end
  end

  assign free_count = tail - head;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= rename_pkg::free_count_t'(rename_pkg::prf_size - rename_pkg::arf_size);
      // Registers above the architectural set start out free
      for (int i = 0; i < rename_pkg::prf_size - rename_pkg::arf_size; i++) begin
        fifo[i] <= rename_pkg::prf_index_t'(rename_pkg::arf_size + i);
      end
    end else begin
      if (restore) begin
        head <= restore_head;
      end else begin
        head <= head + rename_pkg::free_count_t'(alloc_count);
      end
      tail <= tail_next;
      for (int i = 0; i < rename_pkg::commit_width; i++) begin
        if (release_valid[i]) begin
          fifo[rename_pkg::prf_index_t'(wr_ptr[i])] <= release_prd[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
// Speculative architectural to physical map with checkpoint copies
// Lookups are combinational, later slots see earlier writes of the same group
// x0 is never written by the caller and so stays at physical 0
`timescale 1ns/100ps
`default_nettype none

module map_table (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] rs1,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] rs2,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] rd,
  input  logic [rename_pkg::rename_width-1:0]                   rd_write,
  input  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] new_prd,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prs1,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prs2,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prev_prd,
  input  logic                                                  save,
  input  rename_pkg::cp_index_t                                 save_idx,
  input  logic                                                  restore,
  input  rename_pkg::cp_index_t                                 restore_idx
);

  rename_pkg::prf_index_t map      [rename_pkg::arf_size];
  rename_pkg::prf_index_t map_next [rename_pkg::arf_size];
  rename_pkg::prf_index_t cp_map   [rename_pkg::cp_size][rename_pkg::arf_size];

  // Map after the whole group, the younger slot wins on the same rd
  always_comb begin
    map_next = map;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (rd_write[i]) begin
        map_next[rd[i]] = new_prd[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      prs1[i]     = map[rs1[i]];
      prs2[i]     = map[rs2[i]];
      prev_prd[i] = map[rd[i]];
      // Bypass from older slots of the same group
      for (int j = 0; j < i; j++) begin
        if (rd_write[j]) begin
          if (rs1[i] == rd[j]) begin
            prs1[i] = new_prd[j];
          end
          if (rs2[i] == rd[j]) begin
            prs2[i] = new_prd[j];
          end
          if (rd[i] == rd[j]) begin
            prev_prd[i] = new_prd[j];
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::arf_size; i++) begin
        map[i] <= rename_pkg::prf_index_t'(i);
      end
    end else if (restore) begin
      // Restore overrides any write of the squashed group
      for (int i = 0; i < rename_pkg::arf_size; i++) begin
        map[i] <= cp_map[restore_idx][i];
      end
    end else begin
      map <= map_next;
    end
    if (save) begin
      for (int i = 0; i < rename_pkg::arf_size; i++) begin
        cp_map[save_idx][i] <= map_next[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_stage.sv ====
// Rename controller: input register, checkpoint bookkeeping, output register
// A group in flight during a recover edge still comes out, but leaves no state
// ready reserves room for the group taken on the same edge
`timescale 1ns/100ps
`default_nettype none

module rename_stage (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  in_valid,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs1,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs2,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rd,
  input  logic [rename_pkg::rename_width-1:0]                   in_rd_valid,
  input  logic [rename_pkg::rename_width-1:0]                   in_branch,
  output logic                                                  ready,
  output logic                                                  out_valid,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs1,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs2,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prd,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prev_prd,
  output logic [rename_pkg::rename_width-1:0]                   out_prev_valid,
  output rename_pkg::cp_index_t                                 out_cp_index,
  output logic [rename_pkg::rename_width-1:0]                   out_cp_valid,
  input  logic [rename_pkg::commit_width-1:0]                   retire_valid,
  input  rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] retire_prev_prd,
  input  logic [rename_pkg::commit_width-1:0]                   retire_prev_valid,
  input  logic [rename_pkg::commit_width-1:0]                   retire_branch,
  input  logic                                                  recover,
  input  rename_pkg::cp_index_t                                 recover_cp_index,
  output rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rs1,
  output rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rs2,
  output rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rd,
  output logic [rename_pkg::rename_width-1:0]                   map_rd_write,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_new_prd,
  input  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prs1,
  input  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prs2,
  input  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prev_prd,
  output logic                                                  map_save,
  output rename_pkg::cp_index_t                                 map_save_idx,
  output logic                                                  map_restore,
  output rename_pkg::cp_index_t                                 map_restore_idx,
  output logic [1:0]                                            fl_alloc_count,
  input  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] fl_alloc_prd,
  output logic [rename_pkg::commit_width-1:0]                   fl_release_valid,
  output rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] fl_release_prd,
  output logic                                                  fl_restore,
  output rename_pkg::free_count_t                               fl_restore_head,
  input  rename_pkg::free_count_t                               fl_head,
  input  rename_pkg::free_count_t                               fl_free_count
);

  logic                                                  accept;
  logic                                                  buf_valid;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] buf_rs1;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] buf_rs2;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] buf_rd;
  logic [rename_pkg::rename_width-1:0]                   buf_rd_valid;
  logic [rename_pkg::rename_width-1:0]                   buf_branch;

  rename_pkg::cp_index_t   cp_head;
  rename_pkg::cp_index_t   cp_head_next;
  rename_pkg::cp_count_t   cp_count;
  rename_pkg::cp_count_t   cp_count_next;
  rename_pkg::free_count_t cp_free_head [rename_pkg::cp_size];
  rename_pkg::free_count_t free_next;
  rename_pkg::free_count_t pend_alloc;
  logic                    pend_cp;
  logic                    ready_next;

  assign accept  = in_valid & ready;
  assign map_rs1 = buf_rs1;
  assign map_rs2 = buf_rs2;
  assign map_rd  = buf_rd;

  assign map_save        = buf_valid & (|buf_branch) & ~recover;
  assign map_restore     = recover;
  assign map_restore_idx = recover_cp_index;
  assign fl_restore      = recover;
  assign fl_restore_head = cp_free_head[recover_cp_index];
  assign fl_release_prd  = retire_prev_prd;

  // Destination writes and the registers they take, in slot order
  always_comb begin
    fl_alloc_count = '0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      map_rd_write[i] = buf_valid & buf_rd_valid[i] & (buf_rd[i] != '0);
      map_new_prd[i]  = fl_alloc_prd[fl_alloc_count];
      fl_alloc_count  = fl_alloc_count + 2'(map_rd_write[i]);
    end
  end

  always_comb begin
    cp_head_next  = cp_head;
    cp_count_next = cp_count;
    free_next     = fl_free_count;
    // Retirements come before recover and before the new checkpoint
    for (int i = 0; i < rename_pkg::commit_width; i++) begin
      fl_release_valid[i] = retire_valid[i] & retire_prev_valid[i];
      free_next           = free_next + rename_pkg::free_count_t'(fl_release_valid[i]);
      if (retire_valid[i] && retire_branch[i]) begin
        cp_head_next  = cp_head_next + 1'b1;
        cp_count_next = cp_count_next - 1'b1;
      end
    end
    map_save_idx = cp_head_next + rename_pkg::cp_index_t'(cp_count_next);
    if (recover) begin
      // Keep the oldest up to the chosen checkpoint
      cp_count_next = rename_pkg::cp_count_t'(rename_pkg::cp_index_t'(recover_cp_index
                      - cp_head_next)) + 1'b1;
      free_next     = free_next + (fl_head - fl_restore_head);
    end else begin
      cp_count_next = cp_count_next + rename_pkg::cp_count_t'(map_save);
      free_next     = free_next - rename_pkg::free_count_t'(fl_alloc_count);
    end
    // Needs of the group captured on this edge
    pend_alloc = '0;
    pend_cp    = 1'b0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (accept && in_rd_valid[i] && in_rd[i] != '0) begin
        pend_alloc = pend_alloc + 1'b1;
      end
      pend_cp = pend_cp | (accept & in_branch[i]);
    end
    ready_next = (free_next >= pend_alloc + rename_pkg::free_count_t'(rename_pkg::rename_width))
                 && (cp_count_next + rename_pkg::cp_count_t'(pend_cp)
                 < rename_pkg::cp_count_t'(rename_pkg::cp_size));
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cp_head   <= '0;
      cp_count  <= '0;
      ready     <= 1'b1;
      buf_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      cp_head   <= cp_head_next;
      cp_count  <= cp_count_next;
      ready     <= ready_next;
      buf_valid <= accept;
      out_valid <= buf_valid;
    end
    if (accept) begin
      buf_rs1      <= in_rs1;
      buf_rs2      <= in_rs2;
      buf_rd       <= in_rd;
      buf_rd_valid <= in_rd_valid;
      buf_branch   <= in_branch;
    end
    // Free-list head after this group's allocations
    if (map_save) begin
      cp_free_head[map_save_idx] <= fl_head + rename_pkg::free_count_t'(fl_alloc_count);
    end
    out_prs1       <= map_prs1;
    out_prs2       <= map_prs2;
    out_prev_prd   <= map_prev_prd;
    out_prev_valid <= map_rd_write;
    out_cp_index   <= map_save_idx;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      out_prd[i]      <= map_rd_write[i] ? map_new_prd[i] : '0;
      out_cp_valid[i] <= buf_valid & buf_branch[i] & ~recover;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_top.sv ====
// Two-wide register rename, one cycle from accepted group to output
// At most one branch per group, no new group while recover is high
`timescale 1ns/100ps
`default_nettype none

module rename_top (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  in_valid,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs1,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs2,
  input  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rd,
  input  logic [rename_pkg::rename_width-1:0]                   in_rd_valid,
  input  logic [rename_pkg::rename_width-1:0]                   in_branch,
  output logic                                                  ready,
  output logic                                                  out_valid,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs1,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs2,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prd,
  output rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prev_prd,
  output logic [rename_pkg::rename_width-1:0]                   out_prev_valid,
  output rename_pkg::cp_index_t                                 out_cp_index,
  output logic [rename_pkg::rename_width-1:0]                   out_cp_valid,
  input  logic [rename_pkg::commit_width-1:0]                   retire_valid,
  input  rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] retire_prev_prd,
  input  logic [rename_pkg::commit_width-1:0]                   retire_prev_valid,
  input  logic [rename_pkg::commit_width-1:0]                   retire_branch,
  input  logic                                                  recover,
  input  rename_pkg::cp_index_t                                 recover_cp_index
);

  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rs1;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rs2;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] map_rd;
  logic [rename_pkg::rename_width-1:0]                   map_rd_write;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_new_prd;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prs1;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prs2;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] map_prev_prd;
  logic                                                  map_save;
  rename_pkg::cp_index_t                                 map_save_idx;
  logic                                                  map_restore;
  rename_pkg::cp_index_t                                 map_restore_idx;
  logic [1:0]                                            fl_alloc_count;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] fl_alloc_prd;
  logic [rename_pkg::commit_width-1:0]                   fl_release_valid;
  rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] fl_release_prd;
  logic                                                  fl_restore;
  rename_pkg::free_count_t                               fl_restore_head;
  rename_pkg::free_count_t                               fl_head;
  rename_pkg::free_count_t                               fl_free_count;

  rename_stage stage (.*);

  map_table maps (
    .clock       (clock),
    .reset       (reset),
    .rs1         (map_rs1),
    .rs2         (map_rs2),
    .rd          (map_rd),
    .rd_write    (map_rd_write),
    .new_prd     (map_new_prd),
    .prs1        (map_prs1),
    .prs2        (map_prs2),
    .prev_prd    (map_prev_prd),
    .save        (map_save),
    .save_idx    (map_save_idx),
    .restore     (map_restore),
    .restore_idx (map_restore_idx)
  );

  free_list frees (
    .clock         (clock),
    .reset         (reset),
    .alloc_count   (fl_alloc_count),
    .alloc_prd     (fl_alloc_prd),
    .release_valid (fl_release_valid),
    .release_prd   (fl_release_prd),
    .restore       (fl_restore),
    .restore_head  (fl_restore_head),
    .head          (fl_head),
    .free_count    (fl_free_count)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// 8 ns clock, reset high for the first two rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== dv/rename_props.sv ====
// Protocol and occupancy checks on the rename controller
// Output follows an accepted group by exactly one cycle
`timescale 1ns/100ps
`default_nettype none

module rename_props (
  input logic                                clock,
  input logic                                reset,
  input logic                                in_valid,
  input logic                                ready,
  input logic [rename_pkg::rename_width-1:0] in_branch,
  input logic                                recover,
  input logic                                out_valid,
  input rename_pkg::cp_count_t               cp_count
);

  out_after_accept: assert property (@(posedge clock) disable iff (reset)
    out_valid |-> $past(in_valid && ready, 2))
    else $error("out_valid high without a group accepted one edge earlier");

  cp_bounded: assert property (@(posedge clock) disable iff (reset)
    cp_count <= rename_pkg::cp_count_t'(rename_pkg::cp_size))
    else $error("checkpoint occupancy above the table size");

  no_group_on_recover: assert property (@(posedge clock) disable iff (reset)
    !(in_valid && recover))
    else $error("group offered while recover is high");

  one_branch: assert property (@(posedge clock) disable iff (reset)
    in_valid |-> $onehot0(in_branch))
    else $error("more than one branch in a group");

endmodule

`default_nettype wire

// ==== dv/rename_tb.sv ====
// Random two-wide traffic checked against a queue model of map, free list and checkpoints
// Recover is only driven with no group in flight
`timescale 1ns/100ps
`default_nettype none

module rename_tb;

  localparam int group_total = 400;
  localparam int max_cycles  = 50000;
  localparam int ready_limit = 500;

  typedef struct packed {
    logic [31:0]                                           seq;
    rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prs1;
    rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prs2;
    rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prd;
    rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] prev;
    logic [rename_pkg::rename_width-1:0]                   prev_valid;
    logic [rename_pkg::rename_width-1:0]                   branch;
    rename_pkg::cp_index_t                                 cp_index;
  } expect_t;

  typedef struct packed {
    logic [31:0]            seq;
    logic                   branch;
    logic                   prev_valid;
    rename_pkg::prf_index_t prev;
  } rob_entry_t;

  logic                                                  clock;
  logic                                                  reset;
  logic                                                  in_valid;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs1;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rs2;
  rename_pkg::arf_index_t [rename_pkg::rename_width-1:0] in_rd;
  logic [rename_pkg::rename_width-1:0]                   in_rd_valid;
  logic [rename_pkg::rename_width-1:0]                   in_branch;
  logic                                                  ready;
  logic                                                  out_valid;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs1;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prs2;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prd;
  rename_pkg::prf_index_t [rename_pkg::rename_width-1:0] out_prev_prd;
  logic [rename_pkg::rename_width-1:0]                   out_prev_valid;
  rename_pkg::cp_index_t                                 out_cp_index;
  logic [rename_pkg::rename_width-1:0]                   out_cp_valid;
  logic [rename_pkg::commit_width-1:0]                   retire_valid;
  rename_pkg::prf_index_t [rename_pkg::commit_width-1:0] retire_prev_prd;
  logic [rename_pkg::commit_width-1:0]                   retire_prev_valid;
  logic [rename_pkg::commit_width-1:0]                   retire_branch;
  logic                                                  recover;
  rename_pkg::cp_index_t                                 recover_cp_index;

  // Reference model
  logic [31:0]            lfsr;
  rename_pkg::prf_index_t map_m [rename_pkg::arf_size];
  rename_pkg::prf_index_t free_q [$];
  rename_pkg::prf_index_t alloc_log [$];
  rename_pkg::prf_index_t cp_map_m [rename_pkg::cp_size][rename_pkg::arf_size];
  int                     cp_alloc_m [rename_pkg::cp_size];
  int                     cp_seq_m [rename_pkg::cp_size];
  int                     cp_head_m;
  int                     cp_count_m;
  expect_t                pending [$];
  rob_entry_t             rob [$];
  int                     seq_count;
  int                     groups_out;

  tb_clock clocks (
    .clock (clock),
    .reset (reset)
  );

  rename_top dut (.*);

  bind rename_stage rename_props props (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .ready     (ready),
    .in_branch (in_branch),
    .recover   (recover),
    .out_valid (out_valid),
    .cp_count  (cp_count)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end else begin
      return state >> 1;
    end
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_equal(input int got, input int want, input string what);
    assert (got == want) else begin
      fail_now($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, want));
    end
  endtask

  task automatic drive_idle();
    in_valid          = 1'b0;
    in_rs1            = '0;
    in_rs2            = '0;
    in_rd             = '0;
    in_rd_valid       = '0;
    in_branch         = '0;
    retire_valid      = '0;
    retire_prev_prd   = '0;
    retire_prev_valid = '0;
    retire_branch     = '0;
    recover           = 1'b0;
    recover_cp_index  = '0;
  endtask

  // Retire from the oldest entry; no branch retires on a recover edge
  task automatic drive_retire(input logic recovering, input int rate);
    rob_entry_t r;
    for (int i = 0; i < rename_pkg::commit_width; i++) begin
      if (take_bits(3) < rate && rob.size() > 0 && (i == 0 || retire_valid[0])) begin
        if (!(recovering && rob[0].branch)) begin
          r                    = rob.pop_front();
          retire_valid[i]      = 1'b1;
          retire_prev_prd[i]   = r.prev;
          retire_prev_valid[i] = r.prev_valid;
          retire_branch[i]     = r.branch;
        end
      end
    end
  endtask

  task automatic drive_group(input logic branches);
    int pick;
    in_valid = take_bits(2) != 0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      in_rs1[i]      = rename_pkg::arf_index_t'(take_bits(5));
      in_rs2[i]      = rename_pkg::arf_index_t'(take_bits(5));
      in_rd[i]       = rename_pkg::arf_index_t'(take_bits(5));
      in_rd_valid[i] = take_bits(2) != 0;
    end
    // Make slot 1 depend on slot 0 often enough to hit the bypass
    if (take_bits(2) == 0) begin
      in_rs1[1] = in_rd[0];
    end
    if (take_bits(2) == 0) begin
      in_rs2[1] = in_rd[0];
    end
    if (take_bits(2) == 0) begin
      in_rd[1] = in_rd[0];
    end
    pick = take_bits(2);
    if (branches && pick < rename_pkg::rename_width) begin
      in_branch[pick] = 1'b1;
    end
  endtask

  task automatic apply_retire();
    for (int i = 0; i < rename_pkg::commit_width; i++) begin
      if (retire_valid[i] && retire_prev_valid[i]) begin
        free_q.push_back(retire_prev_prd[i]);
      end
      if (retire_valid[i] && retire_branch[i]) begin
        cp_head_m  = (cp_head_m + 1) % rename_pkg::cp_size;
        cp_count_m = cp_count_m - 1;
      end
    end
  endtask

  task automatic apply_recover();
    int idx;
    idx = recover_cp_index;
    for (int r = 0; r < rename_pkg::arf_size; r++) begin
      map_m[r] = cp_map_m[idx][r];
    end
    // Registers taken after the checkpoint go back to the front in order
    while (alloc_log.size() > cp_alloc_m[idx]) begin
      free_q.push_front(alloc_log.pop_back());
    end
    while (rob.size() > 0 && rob[rob.size()-1].seq > cp_seq_m[idx]) begin
      rob.delete(rob.size() - 1);
    end
    cp_count_m = (idx - cp_head_m + rename_pkg::cp_size) % rename_pkg::cp_size + 1;
  endtask

  task automatic rename_group();
    expect_t               e;
    rename_pkg::cp_index_t slot;
    e     = '0;
    e.seq = seq_count;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      e.prs1[i]   = map_m[in_rs1[i]];
      e.prs2[i]   = map_m[in_rs2[i]];
      e.prev[i]   = map_m[in_rd[i]];
      e.branch[i] = in_branch[i];
      if (in_rd_valid[i] && in_rd[i] != '0) begin
        e.prd[i]        = free_q.pop_front();
        e.prev_valid[i] = 1'b1;
        alloc_log.push_back(e.prd[i]);
        map_m[in_rd[i]] = e.prd[i];
      end
    end
    if (|in_branch) begin
      slot = rename_pkg::cp_index_t'((cp_head_m + cp_count_m) % rename_pkg::cp_size);
      for (int r = 0; r < rename_pkg::arf_size; r++) begin
        cp_map_m[slot][r] = map_m[r];
      end
      cp_alloc_m[slot] = alloc_log.size();
      cp_seq_m[slot]   = seq_count;
      cp_count_m       = cp_count_m + 1;
      e.cp_index       = slot;
    end
    pending.push_back(e);
    seq_count = seq_count + 1;
  endtask

  task automatic check_outputs();
    expect_t    e;
    rob_entry_t r;
    assert (out_valid == (pending.size() > 0)) else begin
      fail_now($sformatf("Mismatch at %0t: out_valid is %0b with %0d groups due", $time,
                         out_valid, pending.size()));
    end
    if (out_valid) begin
      e = pending.pop_front();
      for (int i = 0; i < rename_pkg::rename_width; i++) begin
        expect_equal(out_prs1[i], e.prs1[i], $sformatf("slot %0d prs1", i));
        expect_equal(out_prs2[i], e.prs2[i], $sformatf("slot %0d prs2", i));
        expect_equal(out_prev_valid[i], e.prev_valid[i], $sformatf("slot %0d prev_valid", i));
        expect_equal(out_cp_valid[i], e.branch[i], $sformatf("slot %0d cp_valid", i));
        if (e.prev_valid[i]) begin
          expect_equal(out_prd[i], e.prd[i], $sformatf("slot %0d prd", i));
          expect_equal(out_prev_prd[i], e.prev[i], $sformatf("slot %0d prev_prd", i));
        end
        if (e.branch[i]) begin
          expect_equal(out_cp_index, e.cp_index, $sformatf("slot %0d cp_index", i));
        end
        r.seq        = e.seq;
        r.branch     = e.branch[i];
        r.prev_valid = e.prev_valid[i];
        r.prev       = e.prev[i];
        rob.push_back(r);
      end
      groups_out = groups_out + 1;
    end
  endtask

  initial begin
    int   cycle;
    int   stall;
    int   waited;
    int   rate;
    logic burst;
    logic last_ready;
    logic accepted;
    lfsr = 32'ha84a666a;
    drive_idle();
    for (int r = 0; r < rename_pkg::arf_size; r++) begin
      map_m[r] = rename_pkg::prf_index_t'(r);
    end
    for (int p = rename_pkg::arf_size; p < rename_pkg::prf_size; p++) begin
      free_q.push_back(rename_pkg::prf_index_t'(p));
    end
    cp_head_m  = 0;
    cp_count_m = 0;
    seq_count  = 0;
    groups_out = 0;
    last_ready = 1'b0;
    waited     = 0;
    @(posedge clock);
    while (reset !== 1'b0) begin
      waited = waited + 1;
      if (waited > 10) begin
        fail_now("reset was never released");
      end
      @(posedge clock);
    end
    cycle = 0;
    stall = 0;
    while (groups_out < group_total) begin
      #1;
      check_outputs();
      // Inputs still hold what the last edge sampled
      apply_retire();
      if (recover) begin
        apply_recover();
      end
      accepted = in_valid && last_ready;
      if (accepted) begin
        rename_group();
      end
      expect_equal(ready, (free_q.size() >= rename_pkg::rename_width
                   && cp_count_m < rename_pkg::cp_size) ? 1 : 0, "ready");
      last_ready = ready;
      stall      = ready ? 0 : stall + 1;
      if (stall > ready_limit) begin
        fail_now($sformatf("ready stayed low for %0d cycles", stall));
      end
      cycle = cycle + 1;
      if (cycle > max_cycles) begin
        fail_now($sformatf("timeout with only %0d groups renamed", groups_out));
      end
      // Phase 0 drains the free list, phase 2 fills the checkpoints
      burst = (cycle / 64) % 4 == 0;
      rate  = ((cycle / 64) % 2 == 0) ? 1 : 6;
      drive_idle();
      if (cycle > 3 && !burst && !accepted && cp_count_m > 0 && take_bits(2) == 0) begin
        drive_retire(1'b1, rate);
        recover          = 1'b1;
        recover_cp_index = rename_pkg::cp_index_t'((cp_head_m + take_bits(2) % cp_count_m)
                                                   % rename_pkg::cp_size);
      end else begin
        drive_retire(1'b0, rate);
        if (cycle > 3) begin
          drive_group(!burst);
        end
      end
      @(posedge clock);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/rename_stage.sv
logic/rename_top.sv
dv/tb_clock.sv
dv/rename_props.sv
dv/rename_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module rename_tb -o rename_sim; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/rename_sim 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
